// ==== Makefile ====
# Verilator build and run for the z80_vdp testbench

TOP    ?= vdp_tb
SEED   ?= 45
LOG    ?= sim.log
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f vlog.f

run: compile
	./$(OBJDIR)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	@if grep -q "PASS: all tests" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hw/cpu_bus_sync.sv ====
// CPU bus bridge
// brings the asynchronous Z80 read and write strobes into the pixel clock
// domain as single-cycle ticks, samples the data byte and port select with
// the tick and keeps the last read byte steady on cpu_dout for the CPU

`timescale 1ns/1ns

module cpu_bus_sync (
    input  logic                pxclk,
    input  logic                rst_n,

    input  logic                cpu_mode,   // port select, 1 for control and status
    input  vdp_pkg::vdp_byte_t  cpu_din,
    output vdp_pkg::vdp_byte_t  cpu_dout,
    input  logic                cpu_wr,     // asynchronous, active high
    input  logic                cpu_rd,     // asynchronous, active high

    output logic                wr_tick,
    output logic                rd_tick,
    output logic                mode,
    output vdp_pkg::vdp_byte_t  din,
    input  vdp_pkg::vdp_byte_t  dout
);

    logic [2:0] wr_sync;                // bit 0 is the first flop to see the strobe
    logic [2:0] rd_sync;
    logic       wr_edge;
    logic       rd_edge;

    // rising edge seen between the second and third stage
    assign wr_edge = wr_sync[1] & ~wr_sync[2];
    assign rd_edge = rd_sync[1] & ~rd_sync[2];

    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_sync  <= '0;
            rd_sync  <= '0;
            wr_tick  <= 1'b0;
            rd_tick  <= 1'b0;
            mode     <= 1'b0;
            cpu_dout <= '0;
        end else begin
            wr_sync <= {wr_sync[1:0], cpu_wr};
            rd_sync <= {rd_sync[1:0], cpu_rd};
            wr_tick <= wr_edge;             // lands 2 to 3 cycles after the strobe rises
            rd_tick <= rd_edge;
            if (wr_edge || rd_edge)
                mode <= cpu_mode;           // the CPU holds it for the whole strobe
            if (rd_tick)
                cpu_dout <= dout;           // dout is combinational from the port
        end
    end

    // the data byte is stable while cpu_wr is high so it can be sampled with the edge
    always_ff @(posedge pxclk) begin
        if (wr_edge)
            din <= cpu_din;
    end

endmodule

// ==== hw/vdp_pkg.sv ====
// VDP shared definitions
// bus widths, raster counter width, register indices and mode bits
// together with the control latch state and the control command
// used by the CPU port, the renderer and the checker

package vdp_pkg;

    //******************************
    // data widths
    //******************************
    typedef logic [13:0] vdp_addr_t;    // VRAM byte address, 16K reach
    typedef logic [7:0]  vdp_byte_t;    // CPU and VRAM data byte
    typedef logic [3:0]  color_t;       // colour index on the video output
    typedef logic [8:0]  count_t;       // raster counters, wide enough for 342 and 262

    // which byte of a control pair the port expects next
    typedef enum logic {
        CTL_FIRST,
        CTL_SECOND
    } ctl_state_e;

    // command carried in bits 7:6 of the second control byte
    typedef enum logic [1:0] {
        CMD_READ_ADDR  = 2'b00,
        CMD_WRITE_ADDR = 2'b01,
        CMD_REG_WRITE  = 2'b10          // 11 decodes here as well
    } ctl_cmd_e;

    //******************************
    // register file
    //******************************
    localparam int REG_MODE1     = 1;
    localparam int REG_NAME_BASE = 2;   // name table at value * 0x400
    localparam int REG_PAT_BASE  = 4;   // pattern table at value * 0x800
    localparam int REG_COLOR     = 7;   // fg in 7:4, bg in 3:0

    localparam int MODE1_IE      = 5;   // frame interrupt enable
    localparam int MODE1_BLANK_N = 6;   // display enable, blank when clear

endpackage

// ==== hw/vdp_port.sv ====
// VDP CPU port
// decodes control and data accesses from the bus bridge: two-byte control
// latch, eight-entry register file, auto-incrementing VRAM address,
// read-ahead buffer on VRAM port A, frame status flag and the interrupt

`timescale 1ns/1ns

module vdp_port #(
    parameter int VRAM_SIZE = 8192
) (
    input  logic                pxclk,
    input  logic                rst_n,

    input  logic                wr_tick,
    input  logic                rd_tick,
    input  logic                mode,
    input  vdp_pkg::vdp_byte_t  din,
    output vdp_pkg::vdp_byte_t  dout,

    output logic                vram_we,
    output vdp_pkg::vdp_addr_t  vram_waddr,
    output vdp_pkg::vdp_byte_t  vram_wdata,
    output vdp_pkg::vdp_addr_t  vram_raddr,
    input  vdp_pkg::vdp_byte_t  vram_rdata,

    input  logic                frame_tick,

    output logic [3:0]          name_base,
    output logic [2:0]          pat_base,
    output vdp_pkg::color_t     fg,
    output vdp_pkg::color_t     bg,
    output logic                blank_n,
    output logic                irq
);

    import vdp_pkg::*;

    ctl_state_e ctl_state;
    ctl_cmd_e   cmd;
    vdp_byte_t  first_byte;             // low address byte or register value
    vdp_byte_t  regs [8];
    vdp_addr_t  addr;
    vdp_addr_t  next_addr;
    vdp_byte_t  rd_buf;
    logic [1:0] pf_pipe;                // prefetch in flight, bit 1 means rdata is valid
    logic       frame_flag;
    logic       ctl_wr, data_wr, stat_rd, data_rd;
    logic       pf_start;

    assign ctl_wr  = wr_tick & mode;
    assign data_wr = wr_tick & ~mode;
    assign stat_rd = rd_tick & mode;
    assign data_rd = rd_tick & ~mode;

    always_comb begin
        unique case (din[7:6])
            2'b00:   cmd = CMD_READ_ADDR;
            2'b01:   cmd = CMD_WRITE_ADDR;
            default: cmd = CMD_REG_WRITE;
        endcase
    end

    // address wraps at the end of the fitted VRAM
    assign next_addr = (addr == vdp_addr_t'(VRAM_SIZE - 1)) ? '0 : addr + 1'b1;

    // a read address command or a data read both refill the buffer
    assign pf_start = data_rd | (ctl_wr && ctl_state == CTL_SECOND && cmd == CMD_READ_ADDR);

    //******************************
    // control state
    //******************************
    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            ctl_state  <= CTL_FIRST;
            addr       <= '0;
            pf_pipe    <= '0;
            frame_flag <= 1'b0;
            vram_we    <= 1'b0;
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;              // all zero leaves the display blanked
        end else begin
            vram_we <= data_wr;             // write lands one cycle after the tick
            pf_pipe <= {pf_pipe[0], pf_start};

            if (ctl_wr) begin
                if (ctl_state == CTL_FIRST) begin
                    ctl_state <= CTL_SECOND;
                end else begin
                    ctl_state <= CTL_FIRST;
                    if (cmd == CMD_REG_WRITE)
                        regs[din[2:0]] <= first_byte;
                    else
                        addr <= {din[5:0], first_byte};
                end
            end else if (stat_rd) begin
                ctl_state <= CTL_FIRST;     // a status read drops a half-written pair
            end

            if (data_wr || data_rd)
                addr <= next_addr;

            // a frame end in the same cycle as the status read is kept
            if (frame_tick)
                frame_flag <= 1'b1;
            else if (stat_rd)
                frame_flag <= 1'b0;
        end
    end

    always_ff @(posedge pxclk) begin
        if (ctl_wr && ctl_state == CTL_FIRST)
            first_byte <= din;
        if (data_wr) begin
            vram_waddr <= addr;
            vram_wdata <= din;
        end
        if (pf_pipe[1])
            rd_buf <= vram_rdata;           // port A data for the address set two cycles back
    end

    assign vram_raddr = addr;
    assign dout       = mode ? {frame_flag, 7'b0} : rd_buf;

    // register fields seen by the renderer
    assign name_base = regs[REG_NAME_BASE][3:0];
    assign pat_base  = regs[REG_PAT_BASE][2:0];
    assign fg        = regs[REG_COLOR][7:4];
    assign bg        = regs[REG_COLOR][3:0];
    assign blank_n   = regs[REG_MODE1][MODE1_BLANK_N];
    assign irq       = frame_flag & regs[REG_MODE1][MODE1_IE];

endmodule

// ==== hw/vdp_render.sv ====
// VDP pattern renderer
// fetches the name and pattern byte of the next character on VRAM port B
// while the current one is shifted out, picks fg or bg per pixel and
// keeps colour and sync exactly two cycles behind the raster counters

`timescale 1ns/1ns

module vdp_render (
    input  logic                pxclk,
    input  logic                rst_n,
    input  vdp_pkg::count_t     hcount,
    input  vdp_pkg::count_t     vcount,
    input  logic                active,
    input  logic                hsync_raw,
    input  logic                vsync_raw,
    input  logic [3:0]          name_base,
    input  logic [2:0]          pat_base,
    input  vdp_pkg::color_t     fg,
    input  vdp_pkg::color_t     bg,
    input  logic                blank_n,
    output vdp_pkg::vdp_addr_t  vram_raddr,
    input  vdp_pkg::vdp_byte_t  vram_rdata,
    output vdp_pkg::color_t     color,
    output logic                hsync,
    output logic                vsync
);

    import vdp_pkg::*;

    logic [2:0] ph;                     // pixel within the character
    logic [7:0] next_line;
    logic [7:0] f_line;                 // display line of the character being fetched
    logic [4:0] f_col;
    vdp_addr_t  name_addr;
    vdp_addr_t  pat_addr;
    vdp_byte_t  pat_next;               // pattern for the character after this one
    vdp_byte_t  s1_pat;
    logic [2:0] s1_bit;
    logic       s1_on, s1_hs, s1_vs;

    assign ph = hcount[2:0];

    // in the horizontal border the fetch looks ahead to column 0 of the next line
    // lines from 256 up are all border so the top line follows them
    assign next_line = vcount[8] ? 8'd0 : vcount[7:0] + 8'd1;
    assign f_line    = hcount[8] ? next_line : vcount[7:0];
    assign f_col     = hcount[8] ? 5'd0 : hcount[7:3] + 5'd1;

    //******************************
    // fetch, name at 5 and pattern at 6
    //******************************
    assign name_addr  = {name_base, f_line[7:3], f_col};
    assign pat_addr   = {pat_base, vram_rdata, f_line[2:0]};  // rdata holds the name here
    assign vram_raddr = (ph == 3'd6) ? pat_addr : name_addr;

    always_ff @(posedge pxclk) begin
        if (ph == 3'd7)
            pat_next <= vram_rdata;         // pattern byte back from the read at 6
        if (ph == 3'd0)
            s1_pat <= pat_next;             // swap in at the character boundary
        s1_bit <= ph;
    end

    //******************************
    // pixel select and output stage
    //******************************
    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            s1_on <= 1'b0;
            s1_hs <= 1'b1;
            s1_vs <= 1'b1;
            color <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            s1_on <= active & blank_n;
            s1_hs <= hsync_raw;
            s1_vs <= vsync_raw;
            // bit 7 of the pattern is the leftmost pixel
            if (s1_on)
                color <= s1_pat[3'd7 - s1_bit] ? fg : bg;
            else
                color <= '0;
            hsync <= s1_hs;
            vsync <= s1_vs;
        end
    end

endmodule

// ==== hw/vdp_timing.sv ====
// VDP raster timing
// horizontal and vertical counters with sync pulses, the active display
// flag and a one-cycle pulse as the raster enters the bottom border

`timescale 1ns/1ns

module vdp_timing #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 342,
    parameter int V_ACTIVE = 192,
    parameter int V_TOTAL  = 262
) (
    input  logic             pxclk,
    input  logic             rst_n,
    output vdp_pkg::count_t  hcount,
    output vdp_pkg::count_t  vcount,
    output logic             active,
    output logic             hsync_raw,
    output logic             vsync_raw,
    output logic             frame_tick
);

    import vdp_pkg::*;

    localparam int HS_START = H_ACTIVE + 14;   // front porch after the right border
    localparam int HS_END   = HS_START + 26;
    localparam int VS_START = V_ACTIVE + 3;
    localparam int VS_END   = VS_START + 3;

    logic h_last;
    logic v_last;

    assign h_last = (hcount == count_t'(H_TOTAL - 1));
    assign v_last = (vcount == count_t'(V_TOTAL - 1));

    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            hcount     <= '0;
            vcount     <= '0;
            frame_tick <= 1'b0;
        end else begin
            hcount <= h_last ? '0 : hcount + 1'b1;
            if (h_last)
                vcount <= v_last ? '0 : vcount + 1'b1;
            // high for the first cycle with vcount at V_ACTIVE
            frame_tick <= h_last && (vcount == count_t'(V_ACTIVE - 1));
        end
    end

    assign active    = (hcount < count_t'(H_ACTIVE)) && (vcount < count_t'(V_ACTIVE));
    assign hsync_raw = !((hcount >= count_t'(HS_START)) && (hcount < count_t'(HS_END)));
    assign vsync_raw = !((vcount >= count_t'(VS_START)) && (vcount < count_t'(VS_END)));

endmodule

// ==== hw/vdp_vram.sv ====
// VDP video RAM
// one write port from the CPU side and two registered read ports,
// port A for the CPU read-ahead and port B for the renderer

`timescale 1ns/1ns

module vdp_vram #(
    parameter int VRAM_SIZE = 8192
) (
    input  logic                pxclk,
    input  logic                we,
    input  vdp_pkg::vdp_addr_t  waddr,
    input  vdp_pkg::vdp_byte_t  wdata,
    input  vdp_pkg::vdp_addr_t  raddr_a,
    output vdp_pkg::vdp_byte_t  rdata_a,
    input  vdp_pkg::vdp_addr_t  raddr_b,
    output vdp_pkg::vdp_byte_t  rdata_b
);

    localparam int AW = $clog2(VRAM_SIZE);

    logic [7:0] mem [VRAM_SIZE];        // contents are undefined until written

    always_ff @(posedge pxclk) begin
        if (we)
            mem[waddr[AW-1:0]] <= wdata;
        rdata_a <= mem[raddr_a[AW-1:0]];    // both reads take one cycle
        rdata_b <= mem[raddr_b[AW-1:0]];
    end

endmodule

// ==== hw/z80_vdp.sv ====
// Z80 video display processor, top level
// CPU bus bridge, control and data port, dual-read VRAM, raster timing
// and the pattern renderer, all in the pixel clock domain

`timescale 1ns/1ns

module z80_vdp #(
    parameter int VRAM_SIZE = 8192,
    parameter int H_ACTIVE  = 256,
    parameter int H_TOTAL   = 342,
    parameter int V_ACTIVE  = 192,
    parameter int V_TOTAL   = 262
) (
    input  logic                pxclk,
    input  logic                rst_n,
    input  logic                cpu_mode,
    input  vdp_pkg::vdp_byte_t  cpu_din,
    output vdp_pkg::vdp_byte_t  cpu_dout,
    input  logic                cpu_wr,
    input  logic                cpu_rd,
    output vdp_pkg::color_t     color,
    output logic                hsync,
    output logic                vsync,
    output logic                irq
);

    import vdp_pkg::*;

    // bridge to port
    logic       wr_tick, rd_tick, mode;
    vdp_byte_t  din, dout;

    // VRAM ports, A for the CPU side and B for the renderer
    logic       vram_we;
    vdp_addr_t  vram_waddr, vram_raddr_a, vram_raddr_b;
    vdp_byte_t  vram_wdata, vram_rdata_a, vram_rdata_b;

    // register fields and raster
    logic [3:0] name_base;
    logic [2:0] pat_base;
    color_t     fg, bg;
    logic       blank_n, frame_tick, active, hsync_raw, vsync_raw;
    count_t     hcount, vcount;

    cpu_bus_sync u_bus (
        .pxclk(pxclk), .rst_n(rst_n),
        .cpu_mode(cpu_mode), .cpu_din(cpu_din), .cpu_dout(cpu_dout),
        .cpu_wr(cpu_wr), .cpu_rd(cpu_rd),
        .wr_tick(wr_tick), .rd_tick(rd_tick), .mode(mode), .din(din), .dout(dout)
    );

    vdp_port #(.VRAM_SIZE(VRAM_SIZE)) u_port (
        .pxclk(pxclk), .rst_n(rst_n),
        .wr_tick(wr_tick), .rd_tick(rd_tick), .mode(mode), .din(din), .dout(dout),
        .vram_we(vram_we), .vram_waddr(vram_waddr), .vram_wdata(vram_wdata),
        .vram_raddr(vram_raddr_a), .vram_rdata(vram_rdata_a),
        .frame_tick(frame_tick),
        .name_base(name_base), .pat_base(pat_base), .fg(fg), .bg(bg),
        .blank_n(blank_n), .irq(irq)
    );

    vdp_vram #(.VRAM_SIZE(VRAM_SIZE)) u_vram (
        .pxclk(pxclk),
        .we(vram_we), .waddr(vram_waddr), .wdata(vram_wdata),
        .raddr_a(vram_raddr_a), .rdata_a(vram_rdata_a),
        .raddr_b(vram_raddr_b), .rdata_b(vram_rdata_b)
    );

    vdp_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
    ) u_timing (
        .pxclk(pxclk), .rst_n(rst_n),
        .hcount(hcount), .vcount(vcount), .active(active),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .frame_tick(frame_tick)
    );

    vdp_render u_render (
        .pxclk(pxclk), .rst_n(rst_n),
        .hcount(hcount), .vcount(vcount), .active(active),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
        .name_base(name_base), .pat_base(pat_base), .fg(fg), .bg(bg),
        .blank_n(blank_n),
        .vram_raddr(vram_raddr_b), .vram_rdata(vram_rdata_b),
        .color(color), .hsync(hsync), .vsync(vsync)
    );

endmodule

// ==== tests/vdp_chk.sv ====
// VDP protocol checker
// concurrent assertions on the bridge ticks as seen by the CPU port, the
// VRAM write timing, the interrupt and the control latch

`timescale 1ns/1ns

module vdp_chk (
    input logic                 pxclk,
    input logic                 rst_n,
    input logic                 wr_tick,
    input logic                 rd_tick,
    input logic                 mode,
    input logic                 vram_we,
    input logic                 irq,
    input logic                 frame_flag,
    input vdp_pkg::ctl_state_e  ctl_state
);

    import vdp_pkg::*;

    int unsigned fail_count = 0;        // failed assertions so far

    // the bridge never produces a read and a write in one cycle
    ast_one_tick: assert property (@(posedge pxclk) disable iff (!rst_n)
        !(wr_tick && rd_tick))
    else begin
        $error("read and write tick in the same cycle");
        fail_count++;
    end

    ast_wr_pulse: assert property (@(posedge pxclk) disable iff (!rst_n)
        wr_tick |=> !wr_tick)
    else begin
        $error("wr_tick longer than one cycle");
        fail_count++;
    end

    ast_rd_pulse: assert property (@(posedge pxclk) disable iff (!rst_n)
        rd_tick |=> !rd_tick)
    else begin
        $error("rd_tick longer than one cycle");
        fail_count++;
    end

    // data write lands exactly one cycle after its tick
    ast_we_after: assert property (@(posedge pxclk) disable iff (!rst_n)
        (wr_tick && !mode) |=> vram_we)
    else begin
        $error("vram_we missing after data write");
        fail_count++;
    end

    ast_we_cause: assert property (@(posedge pxclk) disable iff (!rst_n)
        vram_we |-> $past(wr_tick && !mode))
    else begin
        $error("vram_we without data write");
        fail_count++;
    end

    ast_irq_flag: assert property (@(posedge pxclk) disable iff (!rst_n)
        irq |-> frame_flag)
    else begin
        $error("irq high with the frame flag clear");
        fail_count++;
    end

    ast_stat_latch: assert property (@(posedge pxclk) disable iff (!rst_n)
        (rd_tick && mode) |=> ctl_state == CTL_FIRST)
    else begin
        $error("latch kept after status read");
        fail_count++;
    end

endmodule

bind vdp_port vdp_chk u_chk (
    .pxclk(pxclk), .rst_n(rst_n),
    .wr_tick(wr_tick), .rd_tick(rd_tick), .mode(mode),
    .vram_we(vram_we), .irq(irq), .frame_flag(frame_flag),
    .ctl_state(ctl_state)
);

// ==== tests/vdp_tb.sv ====
// VDP directed testbench
// drives the Z80 side of z80_vdp with asynchronous strobes, checks the data
// port round trip, sync pulse timing, register effects seen on the colour
// output, blanking, the frame interrupt and recovery of the control latch

`timescale 1ns/1ns

module vdp_tb;

    import vdp_pkg::*;

    localparam int LINE_CYCLES  = 342;
    localparam int FRAME_CYCLES = LINE_CYCLES * 262;   // default raster, one pixel per cycle
    localparam int HS_FIRST     = 256 + 14;            // hsync starts 14 past the active width
    localparam int HS_WIDTH     = 26;
    localparam int VS_LINES     = 3;
    localparam int VRAM_WORDS   = 8192;
    // up to one frame in the sync check, two in the pattern test, one blanked,
    // up to three in the irq test, plus the bus traffic of the name table fill
    localparam int TIMEOUT_CYCLES = 7 * FRAME_CYCLES + 20000;

    logic       pxclk;
    logic       rst_n;
    logic       cpu_mode;
    logic       cpu_wr;
    logic       cpu_rd;
    vdp_byte_t  cpu_din;
    vdp_byte_t  cpu_dout;
    color_t     color;
    logic       hsync;
    logic       vsync;
    logic       irq;
    int         cycles;

    z80_vdp DUT (
        .pxclk(pxclk), .rst_n(rst_n),
        .cpu_mode(cpu_mode), .cpu_din(cpu_din), .cpu_dout(cpu_dout),
        .cpu_wr(cpu_wr), .cpu_rd(cpu_rd),
        .color(color), .hsync(hsync), .vsync(vsync), .irq(irq)
    );

    initial begin
        pxclk = 1'b0;
        forever #50 pxclk = ~pxclk;     // 100 ns pixel clock
    end

    //******************************
    // watchdog
    //******************************
    initial begin
        cycles = 0;
        forever begin
            @(posedge pxclk);
            cycles++;
            if (DUT.u_port.u_chk.fail_count != 0)
                report_problem("a bus protocol assertion failed");
            if (cycles >= TIMEOUT_CYCLES)
                report_problem("tests timed out before finishing");
        end
    end

    //******************************
    // failure reporting and compares
    //******************************
    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR: %s", what);
        fail_run();
    endtask

    task automatic check_byte(input string name, input vdp_byte_t exp, input vdp_byte_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            fail_run();
        end
    endtask

    //******************************
    // CPU bus
    //******************************
    // inputs change 10 ns after the rising edge, outputs are sampled there too
    task automatic next_cycle();
        @(posedge pxclk);
        #10;
    endtask

    task automatic cpu_write(input logic sel, input vdp_byte_t data);
        cpu_mode = sel;                 // 1 selects the control port
        cpu_din  = data;
        cpu_wr   = 1'b1;
        repeat (6) next_cycle();        // longer than the 4 cycle minimum
        cpu_wr = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic cpu_read(input logic sel, output vdp_byte_t data);
        cpu_mode = sel;
        cpu_rd   = 1'b1;
        repeat (6) next_cycle();
        data   = cpu_dout;              // valid 4 cycles after the strobe rose
        cpu_rd = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic set_reg(input int idx, input vdp_byte_t val);
        cpu_write(1'b1, val);
        cpu_write(1'b1, {5'b10000, idx[2:0]});
    endtask

    task automatic set_waddr(input vdp_addr_t a);
        cpu_write(1'b1, a[7:0]);
        cpu_write(1'b1, {2'b01, a[13:8]});
    endtask

    task automatic set_raddr(input vdp_addr_t a);
        cpu_write(1'b1, a[7:0]);
        cpu_write(1'b1, {2'b00, a[13:8]});  // also starts the read-ahead
    endtask

    // every nonzero sample in one frame must be the wanted colour
    task automatic scan_frame(input color_t want, output bit seen);
        seen = 1'b0;
        repeat (FRAME_CYCLES) begin
            next_cycle();
            if (color !== 4'h0) begin
                check_color("color", want, color);
                seen = 1'b1;
            end
        end
    endtask

    // one cycle while waiting for vsync, irq must stay low meanwhile
    task automatic quiet_cycle(inout int n);
        next_cycle();
        n++;
        check_bit("irq", 1'b0, irq);
        if (n > FRAME_CYCLES)
            report_problem("vsync pulse did not arrive within one frame");
    endtask

    task automatic wait_vsync_start();
        int n;
        n = 0;
        while (vsync !== 1'b1)
            quiet_cycle(n);
        while (vsync !== 1'b0)
            quiet_cycle(n);
    endtask

    //******************************
    // tests
    //******************************
    task automatic test_reset_state();
        vdp_byte_t stat;
        cpu_read(1'b1, stat);
        check_byte("status", 8'h00, stat);
        check_bit("irq", 1'b0, irq);
        repeat (342) begin
            next_cycle();
            check_color("color", 4'h0, color);  // all registers zero, display blanked
        end
    endtask

    // sample k after the first low vsync shows pixel k of the first sync line,
    // both syncs carry the same two cycle delay
    task automatic test_sync_timing();
        int   pix;
        logic exp_hs;
        logic exp_vs;
        wait_vsync_start();
        for (int k = 0; k < (VS_LINES + 1) * LINE_CYCLES; k++) begin
            if (k > 0)
                next_cycle();
            pix    = k % LINE_CYCLES;
            exp_hs = !(pix >= HS_FIRST && pix < HS_FIRST + HS_WIDTH);
            exp_vs = (k >= VS_LINES * LINE_CYCLES);
            check_bit("hsync", exp_hs, hsync);
            check_bit("vsync", exp_vs, vsync);
        end
    endtask

    task automatic test_data_roundtrip();
        vdp_addr_t base;
        vdp_byte_t data [32];
        vdp_byte_t got;
        base = vdp_addr_t'($urandom % VRAM_WORDS);
        for (int i = 0; i < 32; i++)
            data[i] = vdp_byte_t'($urandom);
        set_waddr(base);
        for (int i = 0; i < 32; i++)
            cpu_write(1'b0, data[i]);
        set_raddr(base);
        for (int i = 0; i < 32; i++) begin
            cpu_read(1'b0, got);
            check_byte("data", data[i], got);
        end
    endtask

    task automatic test_pattern_colors();
        color_t fg;
        color_t bg;
        bit     seen;
        set_reg(REG_NAME_BASE, 8'h00);      // name table at 0x000
        set_reg(REG_PAT_BASE, 8'h01);       // pattern table at 0x800
        set_waddr(14'h0000);
        repeat (768) cpu_write(1'b0, 8'h00);    // every cell shows pattern 0
        set_waddr(14'h0800);
        repeat (8) cpu_write(1'b0, 8'hff);
        do begin
            fg = color_t'($urandom);
            bg = color_t'($urandom);
        end while (fg == 4'h0 || bg == 4'h0 || fg == bg);
        set_reg(REG_COLOR, {fg, bg});
        set_reg(REG_MODE1, vdp_byte_t'(1 << MODE1_BLANK_N));
        scan_frame(fg, seen);
        if (!seen)
            report_problem("foreground colour never appeared in a full frame");
        set_waddr(14'h0800);
        repeat (8) cpu_write(1'b0, 8'h00);
        repeat (24) next_cycle();           // let the old pattern leave the pipeline
        scan_frame(bg, seen);
        if (!seen)
            report_problem("background colour never appeared in a full frame");
    endtask

    task automatic test_blanking();
        set_reg(REG_MODE1, 8'h00);
        repeat (FRAME_CYCLES) begin
            next_cycle();
            check_color("color", 4'h0, color);
        end
    endtask

    task automatic test_frame_irq();
        vdp_byte_t stat;
        int        waited;
        cpu_read(1'b1, stat);               // clears a flag left from earlier frames
        set_reg(REG_MODE1, vdp_byte_t'(1 << MODE1_IE));
        waited = 0;
        while (irq !== 1'b1) begin
            if (waited > FRAME_CYCLES)
                report_problem("irq did not rise within one frame");
            next_cycle();
            waited++;
        end
        cpu_read(1'b1, stat);
        check_byte("status", 8'h80, stat);
        check_bit("irq", 1'b0, irq);
        set_reg(REG_MODE1, 8'h00);
        // the second vsync lies past a frame end, so the flag is set again
        wait_vsync_start();
        wait_vsync_start();
        cpu_read(1'b1, stat);
        check_byte("status", 8'h80, stat);
        check_bit("irq", 1'b0, irq);
    endtask

    task automatic test_latch_recovery();
        vdp_addr_t target;
        vdp_byte_t val;
        vdp_byte_t got;
        vdp_byte_t stat;
        target = vdp_addr_t'($urandom % VRAM_WORDS);
        val    = vdp_byte_t'($urandom);
        cpu_write(1'b1, 8'h5a);             // lone first byte of a pair
        cpu_read(1'b1, stat);               // drops the half-written pair
        set_waddr(target);
        cpu_write(1'b0, val);
        set_raddr(target);
        cpu_read(1'b0, got);
        check_byte("data", val, got);
    endtask

    initial begin
        rst_n    = 1'b0;
        cpu_mode = 1'b0;
        cpu_din  = 8'h00;
        cpu_wr   = 1'b0;
        cpu_rd   = 1'b0;
        void'($urandom(45));
        repeat (2) @(posedge pxclk);        // reset held for two cycles
        #10;
        rst_n = 1'b1;
        test_reset_state();
        test_sync_timing();
        test_data_roundtrip();
        test_pattern_colors();
        test_blanking();
        test_frame_irq();
        test_latch_recovery();
        if (DUT.u_port.u_chk.fail_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/vdp_pkg.sv
hw/cpu_bus_sync.sv
hw/vdp_port.sv
hw/vdp_vram.sv
hw/vdp_timing.sv
hw/vdp_render.sv
hw/z80_vdp.sv
tests/vdp_chk.sv
tests/vdp_tb.sv
